/* build.f */
common/rd_mux_pkg.sv
common/rd_chan_if.sv
hw/spill_register.sv
hw/ar_arbiter.sv
hw/r_router.sv
hw/rd_mux_top.sv
bench/tb_rd_mux.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_rd_mux
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
LOG       := sim.log

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_rd_mux.sv */
`timescale 1ns/1ps

module tb_rd_mux;
  import rd_mux_pkg::*;

  localparam int unsigned FAIR_CYCLES  = 24;
  localparam int unsigned ARS_PER_PORT = 40;
  localparam int unsigned MAX_CYCLES   = 20000;
  localparam int unsigned DRAIN_CYCLES = 5000;

  logic                    clk_i;
  logic                    reset_i;
  logic [NUM_PORTS-1:0]    slv_ar_valid_i;
  logic [NUM_PORTS-1:0]    slv_ar_ready_o;
  slv_id_t [NUM_PORTS-1:0] slv_ar_id_i;
  addr_t [NUM_PORTS-1:0]   slv_ar_addr_i;
  len_t [NUM_PORTS-1:0]    slv_ar_len_i;
  logic [NUM_PORTS-1:0]    slv_r_valid_o;
  logic [NUM_PORTS-1:0]    slv_r_ready_i;
  slv_id_t [NUM_PORTS-1:0] slv_r_id_o;
  data_t [NUM_PORTS-1:0]   slv_r_data_o;
  logic [NUM_PORTS-1:0]    slv_r_last_o;
  logic                    mst_ar_valid_o;
  logic                    mst_ar_ready_i;
  mst_id_t                 mst_ar_id_o;
  addr_t                   mst_ar_addr_o;
  len_t                    mst_ar_len_o;
  logic                    mst_r_valid_i;
  logic                    mst_r_ready_o;
  mst_id_t                 mst_r_id_i;
  data_t                   mst_r_data_i;
  logic                    mst_r_last_i;

  logic [31:0] rng;
  int          errors;
  int          cyc;
  int          fair_cnt;
  int          ar_seen;
  int          r_sent;
  int          r_seen;
  int          r_expect;
  int          cur;
  int          issued [NUM_PORTS];
  logic        fair_now;
  logic        timed_out;
  port_idx_t   last_ports [NUM_PORTS];
  // Model: ARs accepted per port, expected R beats per master ID
  ar_chan_t        sent_q [NUM_PORTS][$];
  logic [DATA_W:0] exp_r [2**MST_ID_W][$];
  // Memory side: reads accepted on the master port, beats already returned
  ar_chan_t od_ar [$];
  int       od_beat [$];

  rd_mux_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  // Memory content seen by a burst beat
  function automatic data_t beat_data(addr_t addr, int beat);
    return addr + data_t'(beat) * 4;
  endfunction

  function automatic logic all_issued();
    int sum;
    sum = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      sum += issued[p];
    end
    return sum == int'(NUM_PORTS * ARS_PER_PORT);
  endfunction

  function automatic logic drained();
    return (ar_seen == int'(NUM_PORTS * ARS_PER_PORT)) && (r_seen == r_sent) &&
           (od_ar.size() == 0) && (slv_ar_valid_i == '0) && !mst_r_valid_i;
  endfunction

  // ------------------------------
  // Output checks
  // ------------------------------

  task automatic check_master_ar();
    ar_chan_t  got;
    ar_chan_t  exp;
    port_idx_t src;
    logic      distinct;
    if (mst_ar_valid_o && mst_ar_ready_i) begin
      got.id   = mst_ar_id_o;
      got.addr = mst_ar_addr_o;
      got.len  = mst_ar_len_o;
      // Upper ID bits name the sending port
      src = got.id[MST_ID_W-1 -: PORT_IDX_W];
      assert (sent_q[src].size() > 0) else begin
        errors++;
        $display("Master AR with ID %h has no pending request at port %0d", got.id, src);
      end
      if (sent_q[src].size() > 0) begin
        exp = sent_q[src].pop_front();
        assert (got == exp) else begin
          errors++;
          $display("FAILED %0t: master AR %h from port %0d, expected %h", $time, got, src, exp);
        end
      end
      ar_seen++;
      od_ar.push_back(got);
      od_beat.push_back(0);
      // Sliding window of the last NUM_PORTS winners
      if (fair_now) begin
        for (int i = NUM_PORTS - 1; i > 0; i--) begin
          last_ports[i] = last_ports[i-1];
        end
        last_ports[0] = src;
        fair_cnt++;
        if (fair_cnt >= int'(NUM_PORTS)) begin
          distinct = 1'b1;
          for (int i = 0; i < NUM_PORTS; i++) begin
            for (int j = i + 1; j < NUM_PORTS; j++) begin
              if (last_ports[i] == last_ports[j]) distinct = 1'b0;
            end
          end
          assert (distinct) else begin
            errors++;
            $display("FAILED %0t: port %0d won twice within %0d beats", $time, src, NUM_PORTS);
          end
        end
      end
    end
  endtask

  task automatic check_r_ports();
    mst_id_t         mid;
    logic [DATA_W:0] exp;
    assert ($onehot0(slv_r_valid_o)) else begin
      errors++;
      $display("FAILED %0t: R valid at several ports %b", $time, slv_r_valid_o);
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (slv_r_valid_o[p] && slv_r_ready_i[p]) begin
        // Rebuild the master ID from the port it landed on
        mid = {port_idx_t'(p), slv_r_id_o[p]};
        r_seen++;
        assert (exp_r[mid].size() > 0) else begin
          errors++;
          $display("R beat at port %0d with ID %h was never sent by the memory", p, slv_r_id_o[p]);
        end
        if (exp_r[mid].size() > 0) begin
          exp = exp_r[mid].pop_front();
          assert ({slv_r_data_o[p], slv_r_last_o[p]} == exp) else begin
            errors++;
            $display("FAILED %0t: port %0d R data %h last %b, expected %h", $time, p,
                     slv_r_data_o[p], slv_r_last_o[p], exp);
          end
        end
      end
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------

  task automatic run_responder(input logic fair);
    ar_chan_t    ar;
    int          pick;
    logic [31:0] r;
    if (mst_r_valid_i && mst_r_ready_o) begin
      exp_r[mst_r_id_i].push_back({mst_r_data_i, mst_r_last_i});
      r_sent++;
      if (mst_r_last_i) begin
        od_ar.delete(cur);
        od_beat.delete(cur);
      end else begin
        od_beat[cur]++;
      end
    end
    r = next_rand();
    if (!mst_r_valid_i || mst_r_ready_o) begin
      mst_r_valid_i <= 1'b0;
      if (od_ar.size() > 0 && r[1:0] != 2'b00) begin
        pick = int'(next_rand() % od_ar.size());
        // Same ID stays in order, so take the oldest read with that ID
        for (int i = pick - 1; i >= 0; i--) begin
          if (od_ar[i].id == od_ar[pick].id) pick = i;
        end
        cur = pick;
        ar  = od_ar[pick];
        mst_r_valid_i <= 1'b1;
        mst_r_id_i    <= ar.id;
        mst_r_data_i  <= beat_data(ar.addr, od_beat[pick]);
        mst_r_last_i  <= (od_beat[pick] == int'(ar.len));
      end
    end
    mst_ar_ready_i <= fair | (r[3:2] != 2'b00);
    for (int p = 0; p < NUM_PORTS; p++) begin
      slv_r_ready_i[p] <= (r[8+2*p +: 2] != 2'b00);
    end
  endtask

  task automatic drive_requesters(input logic fair);
    ar_chan_t    beat;
    logic [31:0] r;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (slv_ar_valid_i[p] && slv_ar_ready_o[p]) begin
        // Expected master beat, port index above the requester ID
        beat.id   = {port_idx_t'(p), slv_ar_id_i[p]};
        beat.addr = slv_ar_addr_i[p];
        beat.len  = slv_ar_len_i[p];
        sent_q[p].push_back(beat);
        // Each accepted read owes len+1 data beats
        r_expect += int'(slv_ar_len_i[p]) + 1;
      end
      if (!slv_ar_valid_i[p] || slv_ar_ready_o[p]) begin
        r = next_rand();
        if (issued[p] < int'(ARS_PER_PORT) && (fair || r[0])) begin
          slv_ar_valid_i[p] <= 1'b1;
          slv_ar_id_i[p]    <= slv_id_t'(next_rand());
          slv_ar_addr_i[p]  <= next_rand() & ~32'h3;
          slv_ar_len_i[p]   <= len_t'(r[5:4]);
          issued[p]++;
        end else begin
          slv_ar_valid_i[p] <= 1'b0;
        end
      end
    end
  endtask

  task automatic step();
    logic fair_next;
    // All ports busy and AR ready high during the first cycles
    fair_next = (cyc < int'(FAIR_CYCLES));
    check_master_ar();
    check_r_ports();
    run_responder(fair_next);
    drive_requesters(fair_next);
    fair_now = fair_next;
    cyc++;
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    int wait_cnt;
    rng            = 32'h8eb6;
    errors         = 0;
    cyc            = 0;
    fair_cnt       = 0;
    ar_seen        = 0;
    r_sent         = 0;
    r_seen         = 0;
    r_expect       = 0;
    cur            = 0;
    fair_now       = 1'b0;
    timed_out      = 1'b0;
    issued         = '{default: 0};
    reset_i        = 1'b1;
    slv_ar_valid_i = '0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_ar_len_i   = '0;
    slv_r_ready_i  = '0;
    mst_ar_ready_i = 1'b0;
    mst_r_valid_i  = 1'b0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_last_i   = 1'b0;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    assert (!mst_ar_valid_o && slv_r_valid_o == '0) else begin
      errors++;
      $display("FAILED %0t: valid high in reset, AR %b R %b", $time, mst_ar_valid_o,
               slv_r_valid_o);
    end
    while (!all_issued() && !timed_out) begin
      @(posedge clk_i);
      step();
      if (cyc >= int'(MAX_CYCLES)) begin
        timed_out = 1'b1;
        $display("Timeout: requesters did not get all reads accepted");
      end
    end
    wait_cnt = 0;
    while (!drained() && !timed_out) begin
      @(posedge clk_i);
      step();
      wait_cnt++;
      if (wait_cnt >= int'(DRAIN_CYCLES)) begin
        timed_out = 1'b1;
        $display("Timeout: outstanding reads did not drain");
      end
    end
    // Nothing left behind in the model
    for (int p = 0; p < NUM_PORTS; p++) begin
      assert (sent_q[p].size() == 0) else begin
        errors++;
        $display("Port %0d has %0d reads that never left the master port", p, sent_q[p].size());
      end
    end
    for (int i = 0; i < 2**MST_ID_W; i++) begin
      assert (exp_r[i].size() == 0) else begin
        errors++;
        $display("ID %h has %0d R beats that were never delivered", i, exp_r[i].size());
      end
    end
    assert (r_seen == r_expect) else begin
      errors++;
      $display("FAILED %0t: %0d R beats delivered, expected %0d", $time, r_seen, r_expect);
    end
    if (timed_out) errors++;
    $display("Errors: %0d, AR beats: %0d, R beats sent: %0d, R beats delivered: %0d",
             errors, ar_seen, r_sent, r_seen);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* hw/rd_mux_top.sv */
`timescale 1ns/1ps

module rd_mux_top (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  // Requester AR ports
  input  logic                [rd_mux_pkg::NUM_PORTS-1:0] slv_ar_valid_i,
  output logic                [rd_mux_pkg::NUM_PORTS-1:0] slv_ar_ready_o,
  input  rd_mux_pkg::slv_id_t [rd_mux_pkg::NUM_PORTS-1:0] slv_ar_id_i,
  input  rd_mux_pkg::addr_t   [rd_mux_pkg::NUM_PORTS-1:0] slv_ar_addr_i,
  input  rd_mux_pkg::len_t    [rd_mux_pkg::NUM_PORTS-1:0] slv_ar_len_i,
  // Requester R ports
  output logic                [rd_mux_pkg::NUM_PORTS-1:0] slv_r_valid_o,
  input  logic                [rd_mux_pkg::NUM_PORTS-1:0] slv_r_ready_i,
  output rd_mux_pkg::slv_id_t [rd_mux_pkg::NUM_PORTS-1:0] slv_r_id_o,
  output rd_mux_pkg::data_t   [rd_mux_pkg::NUM_PORTS-1:0] slv_r_data_o,
  output logic                [rd_mux_pkg::NUM_PORTS-1:0] slv_r_last_o,
  // Master AR port
  output logic                                            mst_ar_valid_o,
  input  logic                                            mst_ar_ready_i,
  output rd_mux_pkg::mst_id_t                             mst_ar_id_o,
  output rd_mux_pkg::addr_t                               mst_ar_addr_o,
  output rd_mux_pkg::len_t                                mst_ar_len_o,
  // Master R port
  input  logic                                            mst_r_valid_i,
  output logic                                            mst_r_ready_o,
  input  rd_mux_pkg::mst_id_t                             mst_r_id_i,
  input  rd_mux_pkg::data_t                               mst_r_data_i,
  input  logic                                            mst_r_last_i
);
  import rd_mux_pkg::*;

  rd_req_if ar_if ();
  rd_rsp_if r_if ();

  ar_chan_t ar_in, ar_out;
  r_chan_t  r_in, r_out;

  // ------------------------------
  // AR path
  // ------------------------------

  ar_arbiter i_ar_arbiter (
    .clk_i       ( clk_i          ),
    .reset_i     ( reset_i        ),
    .req_valid_i ( slv_ar_valid_i ),
    .req_ready_o ( slv_ar_ready_o ),
    .req_id_i    ( slv_ar_id_i    ),
    .req_addr_i  ( slv_ar_addr_i  ),
    .req_len_i   ( slv_ar_len_i   ),
    .out         ( ar_if          )
  );

  assign ar_in.id   = ar_if.id;
  assign ar_in.addr = ar_if.addr;
  assign ar_in.len  = ar_if.len;

  // Cuts the arbiter's combinational path off the master port
  spill_register #(
    .T ( ar_chan_t )
  ) i_ar_spill (
    .clk_i   ( clk_i          ),
    .reset_i ( reset_i        ),
    .valid_i ( ar_if.valid    ),
    .ready_o ( ar_if.ready    ),
    .data_i  ( ar_in          ),
    .valid_o ( mst_ar_valid_o ),
    .ready_i ( mst_ar_ready_i ),
    .data_o  ( ar_out         )
  );

  assign mst_ar_id_o   = ar_out.id;
  assign mst_ar_addr_o = ar_out.addr;
  assign mst_ar_len_o  = ar_out.len;

  // ------------------------------
  // R path
  // ------------------------------

  assign r_in.id   = mst_r_id_i;
  assign r_in.data = mst_r_data_i;
  assign r_in.last = mst_r_last_i;

  // Registers the incoming response before the routing decode
  spill_register #(
    .T ( r_chan_t )
  ) i_r_spill (
    .clk_i   ( clk_i         ),
    .reset_i ( reset_i       ),
    .valid_i ( mst_r_valid_i ),
    .ready_o ( mst_r_ready_o ),
    .data_i  ( r_in          ),
    .valid_o ( r_if.valid    ),
    .ready_i ( r_if.ready    ),
    .data_o  ( r_out         )
  );

  assign r_if.id   = r_out.id;
  assign r_if.data = r_out.data;
  assign r_if.last = r_out.last;

  r_router i_r_router (
    .in          ( r_if          ),
    .rsp_valid_o ( slv_r_valid_o ),
    .rsp_ready_i ( slv_r_ready_i ),
    .rsp_id_o    ( slv_r_id_o    ),
    .rsp_data_o  ( slv_r_data_o  ),
    .rsp_last_o  ( slv_r_last_o  )
  );

endmodule

/* hw/r_router.sv */
`timescale 1ns/1ps

module r_router (
  rd_rsp_if.sink                                          in,
  output logic                [rd_mux_pkg::NUM_PORTS-1:0] rsp_valid_o,
  input  logic                [rd_mux_pkg::NUM_PORTS-1:0] rsp_ready_i,
  output rd_mux_pkg::slv_id_t [rd_mux_pkg::NUM_PORTS-1:0] rsp_id_o,
  output rd_mux_pkg::data_t   [rd_mux_pkg::NUM_PORTS-1:0] rsp_data_o,
  output logic                [rd_mux_pkg::NUM_PORTS-1:0] rsp_last_o
);
  import rd_mux_pkg::*;

  // Target port taken from the prepended index bits
  port_idx_t dst;

  assign dst = in.id[MST_ID_W-1 -: PORT_IDX_W];

  // ------------------------------
  // Handshake steering
  // ------------------------------

  // One-hot valid, nothing raised without an incoming beat
  always_comb begin
    rsp_valid_o      = '0;
    rsp_valid_o[dst] = in.valid;
  end

  // Only the addressed port can stall the channel
  assign in.ready = rsp_ready_i[dst];

  // ------------------------------
  // Payload fan-out
  // ------------------------------

  // Every port sees the same payload, valid picks the one that takes it
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_fanout
    // Index bits are stripped, requester gets its own ID back
    assign rsp_id_o[i]   = in.id[SLV_ID_W-1:0];
    assign rsp_data_o[i] = in.data;
    assign rsp_last_o[i] = in.last;
  end

endmodule

/* hw/ar_arbiter.sv */
`timescale 1ns/1ps

module ar_arbiter (
  input  logic                                              clk_i,
  input  logic                                              reset_i,
  input  logic                [rd_mux_pkg::NUM_PORTS-1:0]   req_valid_i,
  output logic                [rd_mux_pkg::NUM_PORTS-1:0]   req_ready_o,
  input  rd_mux_pkg::slv_id_t [rd_mux_pkg::NUM_PORTS-1:0]   req_id_i,
  input  rd_mux_pkg::addr_t   [rd_mux_pkg::NUM_PORTS-1:0]   req_addr_i,
  input  rd_mux_pkg::len_t    [rd_mux_pkg::NUM_PORTS-1:0]   req_len_i,
  rd_req_if.source                                          out
);
  import rd_mux_pkg::*;

  // Last port that won a transfer
  port_idx_t rr_q, rr_d;
  // Winner held while the downstream stalls
  logic      lock_q, lock_d;
  port_idx_t lock_idx_q, lock_idx_d;
  // Current choice
  port_idx_t sel;
  port_idx_t cand;
  logic      sel_found;
  logic      offer;

  // ------------------------------
  // Winner selection
  // ------------------------------

  always_comb begin
    sel       = lock_idx_q;
    sel_found = lock_q;
    cand      = rr_q;
    if (!lock_q) begin
      // Search starts one past the last grant and wraps
      for (int k = 1; k <= NUM_PORTS; k++) begin
        cand = port_idx_t'((int'(rr_q) + k) % NUM_PORTS);
        if (!sel_found && req_valid_i[cand]) begin
          sel       = cand;
          sel_found = 1'b1;
        end
      end
    end
  end

  assign offer = sel_found & req_valid_i[sel];

  // ------------------------------
  // Outgoing beat
  // ------------------------------

  assign out.valid = offer;
  // Port index goes above the requester ID
  assign out.id    = {sel, req_id_i[sel]};
  assign out.addr  = req_addr_i[sel];
  assign out.len   = req_len_i[sel];

  // Only the winner sees the downstream ready
  always_comb begin
    req_ready_o      = '0;
    req_ready_o[sel] = offer & out.ready;
  end

  // ------------------------------
  // Pointer and lock
  // ------------------------------

  always_comb begin
    rr_d       = rr_q;
    lock_idx_d = lock_idx_q;
    // Hold the choice while a beat waits
    lock_d     = offer & ~out.ready;
    if (offer) begin
      lock_idx_d = sel;
      if (out.ready) begin
        rr_d = sel;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // First search begins at port 0
      rr_q       <= port_idx_t'(NUM_PORTS - 1);
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      rr_q       <= rr_d;
      lock_q     <= lock_d;
      lock_idx_q <= lock_idx_d;
    end
  end

endmodule

/* hw/spill_register.sv */
`timescale 1ns/1ps

module spill_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic reset_i,
  // Upstream side
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  // Downstream side
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Slot A takes new beats, slot B holds a beat that could not leave
  T     a_data_q, b_data_q;
  logic a_full_q, a_full_d;
  logic b_full_q, b_full_d;
  logic ready_q;
  logic a_fill, a_drain;
  logic b_fill, b_drain;

  // Accept while at least one slot is free
  assign a_fill  = valid_i & ready_q;
  // A empties each cycle B is free, either out or into B
  assign a_drain = a_full_q & ~b_full_q;
  // A stalled beat spills into B
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  assign a_full_d = a_fill | (a_full_q & ~a_drain);
  assign b_full_d = b_fill | (b_full_q & ~b_drain);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      a_full_q <= a_full_d;
      b_full_q <= b_full_d;
      // Ready for the next cycle, low only when both slots are taken
      ready_q  <= ~(a_full_d & b_full_d);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // B is always older than A, so it goes first
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign ready_o = ready_q;

endmodule

/* common/rd_chan_if.sv */
`timescale 1ns/1ps

// Read address channel between the arbiter and the AR spill register
interface rd_req_if;
  import rd_mux_pkg::*;

  logic    valid;
  logic    ready;
  // Master-side ID, port index in the upper bits
  mst_id_t id;
  addr_t   addr;
  len_t    len;

  // Side that offers beats
  modport source (
    output valid, id, addr, len,
    input  ready
  );

  // Side that takes beats
  modport sink (
    input  valid, id, addr, len,
    output ready
  );

endinterface

// Read data channel between the R spill register and the router
interface rd_rsp_if;
  import rd_mux_pkg::*;

  logic    valid;
  logic    ready;
  mst_id_t id;
  data_t   data;
  logic    last;

  modport source (
    output valid, id, data, last,
    input  ready
  );

  modport sink (
    input  valid, id, data, last,
    output ready
  );

endinterface

/* common/rd_mux_pkg.sv */
package rd_mux_pkg;

  // ------------------------------
  // Widths
  // ------------------------------

  // Requester ports merged onto the one master port
  localparam int unsigned NUM_PORTS  = 4;
  // ID width as seen by each requester
  localparam int unsigned SLV_ID_W   = 4;
  // Port index bits prepended above the requester ID
  localparam int unsigned PORT_IDX_W = $clog2(NUM_PORTS);
  localparam int unsigned MST_ID_W   = SLV_ID_W + PORT_IDX_W;
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned LEN_W      = 8;

  // ------------------------------
  // Field types
  // ------------------------------

  typedef logic [SLV_ID_W-1:0]   slv_id_t;
  typedef logic [MST_ID_W-1:0]   mst_id_t;
  typedef logic [PORT_IDX_W-1:0] port_idx_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [LEN_W-1:0]      len_t;

  // Read address beat on the master side, ID already extended
  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } ar_chan_t;

  // Read data beat on the master side
  typedef struct packed {
    mst_id_t id;
    data_t   data;
    logic    last;
  } r_chan_t;

endpackage
